//--- all.f
+incdir+source
source/db_ctrl_pkg.sv
source/power_regs.sv
source/switch_regs.sv
source/ctrlport_resp_combiner.sv
source/db_ctrl_top.sv
testbench/db_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the db_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -f all.f --top-module db_ctrl_tb \
    -Mdir obj_dir -o db_ctrl_sim > build.log 2>&1 \
  && ./obj_dir/db_ctrl_sim > sim.log 2>&1 \
  && grep -q "^RESULT: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- testbench/db_ctrl_tb.sv
`timescale 1ns/1ps

`include "db_ctrl_cfg.svh"

module db_ctrl_tb;

  // random part issues one request per cycle
  localparam int NUM_RANDOM     = 500;
  // directed part stays under 150 cycles, so 2000 leaves wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                        ctrlport_clk;
  logic                        ctrlport_rst;
  db_ctrl_pkg::ctrlport_req_t  s_ctrlport_req;
  db_ctrl_pkg::ctrlport_resp_t s_ctrlport_resp;
  logic                        enable_tx_7v0;
  logic                        enable_rx_7v0;
  logic                        enable_3v3;
  logic                        p7v_pg_a;
  logic                        p7v_pg_b;
  logic                        pll_ref_clk_enable;
  logic [1:0]                  tx_ant_sel;
  logic [1:0]                  rx_ant_sel;

  // shadow copy of every register
  logic        shadow_tx_7v0;
  logic        shadow_rx_7v0;
  logic        shadow_3v3;
  logic        shadow_pll_en;
  logic [1:0]  shadow_tx_sel;
  logic [1:0]  shadow_rx_sel;
  logic [31:0] shadow_scratch;

  // expected responses in issue order
  db_ctrl_pkg::ctrlport_resp_t exp_q[$];
  int                          cycle_q[$];
  string                       name_q[$];

  int   cycle_cnt = 0;
  logic in_reset  = 1'b1;
  int   err_cnt   = 0;
  int   check_cnt = 0;
  // power-good levels applied with the next request
  logic pg_a_next;
  logic pg_b_next;

  db_ctrl_top u_db_ctrl_top (
    .ctrlport_clk       (ctrlport_clk),
    .ctrlport_rst       (ctrlport_rst),
    .s_ctrlport_req     (s_ctrlport_req),
    .s_ctrlport_resp    (s_ctrlport_resp),
    .enable_tx_7v0      (enable_tx_7v0),
    .enable_rx_7v0      (enable_rx_7v0),
    .enable_3v3         (enable_3v3),
    .p7v_pg_a           (p7v_pg_a),
    .p7v_pg_b           (p7v_pg_b),
    .pll_ref_clk_enable (pll_ref_clk_enable),
    .tx_ant_sel         (tx_ant_sel),
    .rx_ant_sel         (rx_ant_sel)
  );

  // ------------------------------
  // clock, cycle count, timeout
  // ------------------------------
  initial begin
    ctrlport_clk = 1'b0;
    forever #4 ctrlport_clk = ~ctrlport_clk;
  end

  always @(posedge ctrlport_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    in_reset  <= ctrlport_rst;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", check_cnt, err_cnt + 1);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic db_ctrl_pkg::ctrlport_resp_t ref_access(
    input logic        wr,
    input logic        rd,
    input logic [19:0] addr,
    input logic [31:0] wdata,
    input logic        pg_a,
    input logic        pg_b
  );
    db_ctrl_pkg::ctrlport_resp_t resp;
    logic [19:0]                 pwr_off;
    logic [19:0]                 sw_off;
    pwr_off     = addr - `DB_CTRL_POWER_BASE;
    sw_off      = addr - `DB_CTRL_SWITCH_BASE;
    resp.ack    = 1'b1;
    resp.status = db_ctrl_pkg::ctrl_sts_okay;
    resp.data   = '0;
    if (!(wr || rd)) begin
      resp.ack = 1'b0;
    end else if (pwr_off < `DB_CTRL_POWER_SIZE) begin
      case (pwr_off)
        `RF_POWER_CONTROL: begin
          if (wr) begin
            shadow_tx_7v0 = wdata[`ENABLE_TX_7V0];
            shadow_rx_7v0 = wdata[`ENABLE_RX_7V0];
            shadow_3v3    = wdata[`ENABLE_3V3];
          end else begin
            resp.data[`ENABLE_TX_7V0] = shadow_tx_7v0;
            resp.data[`ENABLE_RX_7V0] = shadow_rx_7v0;
            resp.data[`ENABLE_3V3]    = shadow_3v3;
          end
        end
        `RF_POWER_STATUS: begin
          // read only
          if (wr) begin
            resp.status = db_ctrl_pkg::ctrl_sts_cmderr;
          end else begin
            resp.data[`P7V_A_STATUS] = pg_a;
            resp.data[`P7V_B_STATUS] = pg_b;
          end
        end
        `PRC_CONTROL: begin
          if (wr) begin
            shadow_pll_en = wdata[`PLL_REF_CLOCK_ENABLE];
          end else begin
            resp.data[`PLL_REF_CLOCK_ENABLE] = shadow_pll_en;
          end
        end
        default: begin
          resp.status = db_ctrl_pkg::ctrl_sts_cmderr;
        end
      endcase
    end else if (sw_off < `DB_CTRL_SWITCH_SIZE) begin
      case (sw_off)
        `SWITCH_CONTROL: begin
          if (wr) begin
            shadow_tx_sel = wdata[1:0];
            shadow_rx_sel = wdata[5:4];
          end else begin
            resp.data[1:0] = shadow_tx_sel;
            resp.data[5:4] = shadow_rx_sel;
          end
        end
        `SWITCH_SCRATCH: begin
          if (wr) begin
            shadow_scratch = wdata;
          end else begin
            resp.data = shadow_scratch;
          end
        end
        default: begin
          resp.status = db_ctrl_pkg::ctrl_sts_cmderr;
        end
      endcase
    end else begin
      // unmapped, nobody answers
      resp.ack = 1'b0;
    end
    return resp;
  endfunction

  // ------------------------------
  // check helpers
  // ------------------------------
  task automatic check_value(input string name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_cnt++;
    assert (actual === expected) else begin
      err_cnt++;
      $display("CHECK FAILED %s %s: expected %h actual %h", name, field, expected, actual);
    end
  endtask

  // pins reflect every request issued before this falling edge
  task automatic check_pins(input string name);
    check_value(name, "enable_tx_7v0", 32'(shadow_tx_7v0), 32'(enable_tx_7v0));
    check_value(name, "enable_rx_7v0", 32'(shadow_rx_7v0), 32'(enable_rx_7v0));
    check_value(name, "enable_3v3", 32'(shadow_3v3), 32'(enable_3v3));
    check_value(name, "pll_ref_clk_enable", 32'(shadow_pll_en), 32'(pll_ref_clk_enable));
    check_value(name, "tx_ant_sel", 32'(shadow_tx_sel), 32'(tx_ant_sel));
    check_value(name, "rx_ant_sel", 32'(shadow_rx_sel), 32'(rx_ant_sel));
  endtask

  // ------------------------------
  // driver tasks
  // ------------------------------
  task automatic issue(input logic wr, input logic rd, input logic [19:0] addr,
                       input logic [31:0] data, input string name);
    db_ctrl_pkg::ctrlport_resp_t exp;
    @(negedge ctrlport_clk);
    check_pins(name);
    p7v_pg_a            = pg_a_next;
    p7v_pg_b            = pg_b_next;
    s_ctrlport_req.wr   = wr;
    s_ctrlport_req.rd   = rd;
    s_ctrlport_req.addr = addr;
    s_ctrlport_req.data = data;
    exp = ref_access(wr, rd, addr, data, p7v_pg_a, p7v_pg_b);
    exp_q.push_back(exp);
    cycle_q.push_back(cycle_cnt);
    name_q.push_back(name);
  endtask

  task automatic idle(input int cycles, input string name);
    repeat (cycles) begin
      @(negedge ctrlport_clk);
      check_pins(name);
      s_ctrlport_req = '0;
    end
  endtask

  // ------------------------------
  // response checker
  // ------------------------------
  // head entry is due two cycles after it was issued
  always @(negedge ctrlport_clk) begin
    if (!in_reset) begin
      if (exp_q.size() > 0 && cycle_q[0] == cycle_cnt - 2) begin
        check_value(name_q[0], "ack", 32'(exp_q[0].ack), 32'(s_ctrlport_resp.ack));
        if (exp_q[0].ack) begin
          check_value(name_q[0], "status", 32'(exp_q[0].status), 32'(s_ctrlport_resp.status));
          check_value(name_q[0], "data", exp_q[0].data, s_ctrlport_resp.data);
        end
        void'(exp_q.pop_front());
        void'(cycle_q.pop_front());
        void'(name_q.pop_front());
      end else begin
        check_cnt++;
        assert (s_ctrlport_resp.ack === 1'b0) else begin
          err_cnt++;
          $display("ack seen at cycle %0d with no request due", cycle_cnt);
        end
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : stimulus
    int          sel;
    logic [19:0] rnd_addr;
    logic [31:0] rnd_data;
    logic        rnd_wr;
    void'($urandom(54161));
    ctrlport_rst   = 1'b1;
    s_ctrlport_req = '0;
    p7v_pg_a       = 1'b0;
    p7v_pg_b       = 1'b0;
    pg_a_next      = 1'b1;
    pg_b_next      = 1'b0;
    shadow_tx_7v0  = 1'b0;
    shadow_rx_7v0  = 1'b0;
    shadow_3v3     = 1'b0;
    shadow_pll_en  = 1'b0;
    shadow_tx_sel  = 2'b00;
    shadow_rx_sel  = 2'b00;
    shadow_scratch = '0;
    repeat (3) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;

    // reset state, status shows the driven levels
    idle(2, "reset");
    issue(1'b0, 1'b1, 20'h00, '0, "reset");
    issue(1'b0, 1'b1, 20'h04, '0, "reset");
    issue(1'b0, 1'b1, 20'h08, '0, "reset");
    issue(1'b0, 1'b1, 20'h10, '0, "reset");
    issue(1'b0, 1'b1, 20'h14, '0, "reset");
    idle(3, "reset");

    // write and read back, all ones first
    for (int i = 0; i < 5; i++) begin
      rnd_data = (i == 0) ? 32'hffff_ffff : $urandom;
      issue(1'b1, 1'b0, 20'h00, rnd_data, "readback");
      issue(1'b1, 1'b0, 20'h08, ~rnd_data, "readback");
      issue(1'b1, 1'b0, 20'h10, rnd_data, "readback");
      issue(1'b1, 1'b0, 20'h14, rnd_data ^ 32'h5a5a_a5a5, "readback");
      issue(1'b0, 1'b1, 20'h00, '0, "readback");
      issue(1'b0, 1'b1, 20'h08, '0, "readback");
      issue(1'b0, 1'b1, 20'h10, '0, "readback");
      issue(1'b0, 1'b1, 20'h14, '0, "readback");
      idle(1, "readback");
    end

    // power-good follows the pins, status is read only
    for (int i = 0; i < 16; i++) begin
      pg_a_next = 1'($urandom % 2);
      pg_b_next = 1'($urandom % 2);
      issue(1'b0, 1'b1, 20'h04, '0, "pgood");
    end
    issue(1'b1, 1'b0, 20'h04, 32'hffff_ffff, "pgood");
    issue(1'b0, 1'b1, 20'h00, '0, "pgood");
    issue(1'b0, 1'b1, 20'h04, '0, "pgood");
    idle(3, "pgood");

    // holes answer cmderr, unmapped stays silent
    issue(1'b0, 1'b1, 20'h0c, '0, "errors");
    issue(1'b1, 1'b0, 20'h0c, 32'hffff_ffff, "errors");
    issue(1'b0, 1'b1, 20'h02, '0, "errors");
    issue(1'b0, 1'b1, 20'h18, '0, "errors");
    issue(1'b1, 1'b0, 20'h1c, 32'hffff_ffff, "errors");
    issue(1'b0, 1'b1, 20'h11, '0, "errors");
    issue(1'b0, 1'b1, 20'h20, '0, "errors");
    issue(1'b1, 1'b0, 20'h24, 32'hffff_ffff, "errors");
    issue(1'b0, 1'b1, 20'h100, '0, "errors");
    issue(1'b1, 1'b0, 20'hffffc, 32'hffff_ffff, "errors");
    idle(4, "errors");

    // back to back, mostly inside the windows
    for (int i = 0; i < NUM_RANDOM; i++) begin
      sel = int'($urandom % 8);
      if (sel == 0) begin
        rnd_addr = 20'($urandom);
      end else if (sel == 1) begin
        rnd_addr = 20'($urandom % 64);
      end else begin
        rnd_addr = 20'(($urandom % 12) * 4);
      end
      if (i % 8 == 0) begin
        pg_a_next = 1'($urandom % 2);
        pg_b_next = 1'($urandom % 2);
      end
      rnd_wr   = 1'($urandom % 2);
      rnd_data = $urandom;
      issue(rnd_wr, ~rnd_wr, rnd_addr, rnd_data, "random");
    end
    idle(4, "drain");

    check_cnt++;
    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("%0d responses never came back", exp_q.size());
    end
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/db_ctrl_top.sv
`timescale 1ns/1ps

`include "db_ctrl_cfg.svh"

module db_ctrl_top (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  // host side ctrlport
  input  db_ctrl_pkg::ctrlport_req_t  s_ctrlport_req,
  output db_ctrl_pkg::ctrlport_resp_t s_ctrlport_resp,
  // power pins
  output logic                        enable_tx_7v0,
  output logic                        enable_rx_7v0,
  output logic                        enable_3v3,
  input  logic                        p7v_pg_a,
  input  logic                        p7v_pg_b,
  output logic                        pll_ref_clk_enable,
  // rf switch pins
  output logic [1:0]                  tx_ant_sel,
  output logic [1:0]                  rx_ant_sel
);

  // per block responses, one cycle after the request
  db_ctrl_pkg::ctrlport_resp_t power_resp;
  db_ctrl_pkg::ctrlport_resp_t switch_resp;

  // ------------------------------
  // register blocks
  // ------------------------------
  // same request goes to both, each decodes its own window
  power_regs #(
    .BASE_ADDRESS (`DB_CTRL_POWER_BASE),
    .SIZE_ADDRESS (`DB_CTRL_POWER_SIZE)
  ) u_power_regs (
    .ctrlport_clk       (ctrlport_clk),
    .ctrlport_rst       (ctrlport_rst),
    .s_ctrlport_req     (s_ctrlport_req),
    .s_ctrlport_resp    (power_resp),
    .enable_tx_7v0      (enable_tx_7v0),
    .enable_rx_7v0      (enable_rx_7v0),
    .enable_3v3         (enable_3v3),
    .p7v_pg_a           (p7v_pg_a),
    .p7v_pg_b           (p7v_pg_b),
    .pll_ref_clk_enable (pll_ref_clk_enable)
  );

  switch_regs #(
    .BASE_ADDRESS (`DB_CTRL_SWITCH_BASE),
    .SIZE_ADDRESS (`DB_CTRL_SWITCH_SIZE)
  ) u_switch_regs (
    .ctrlport_clk    (ctrlport_clk),
    .ctrlport_rst    (ctrlport_rst),
    .s_ctrlport_req  (s_ctrlport_req),
    .s_ctrlport_resp (switch_resp),
    .tx_ant_sel      (tx_ant_sel),
    .rx_ant_sel      (rx_ant_sel)
  );

  // ------------------------------
  // response merge
  // ------------------------------
  // adds the second cycle of latency
  ctrlport_resp_combiner u_resp_combiner (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .power_resp   (power_resp),
    .switch_resp  (switch_resp),
    .m_resp       (s_ctrlport_resp)
  );

endmodule

//--- source/ctrlport_resp_combiner.sv
`timescale 1ns/1ps

module ctrlport_resp_combiner (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  // one response per register block
  input  db_ctrl_pkg::ctrlport_resp_t power_resp,
  input  db_ctrl_pkg::ctrlport_resp_t switch_resp,
  // merged response
  output db_ctrl_pkg::ctrlport_resp_t m_resp
);

  logic                      merged_ack;
  logic [1:0]                merged_status;
  logic [31:0]               merged_data;
  logic                      resp_ack_q;
  db_ctrl_pkg::ctrl_status_t resp_status_q;
  logic [31:0]               resp_data_q;

  // ------------------------------
  // mask and merge
  // ------------------------------
  // windows are disjoint, so at most one side is acked
  assign merged_ack = power_resp.ack | switch_resp.ack;

  // a silent block contributes zeros
  assign merged_status = ({2{power_resp.ack}} & power_resp.status) |
                         ({2{switch_resp.ack}} & switch_resp.status);
  assign merged_data   = ({32{power_resp.ack}} & power_resp.data) |
                         ({32{switch_resp.ack}} & switch_resp.data);

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack_q <= 1'b0;
    end else begin
      resp_ack_q <= merged_ack;
    end
  end

  // payload, only meaningful with ack
  always_ff @(posedge ctrlport_clk) begin
    resp_status_q <= db_ctrl_pkg::ctrl_status_t'(merged_status);
    resp_data_q   <= merged_data;
  end

  assign m_resp = '{ack: resp_ack_q, status: resp_status_q, data: resp_data_q};

endmodule

//--- source/switch_regs.sv
`timescale 1ns/1ps

`include "db_ctrl_cfg.svh"

module switch_regs #(
  parameter logic [19:0] BASE_ADDRESS = `DB_CTRL_SWITCH_BASE,
  parameter logic [19:0] SIZE_ADDRESS = `DB_CTRL_SWITCH_SIZE
) (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  // ctrlport request and response
  input  db_ctrl_pkg::ctrlport_req_t  s_ctrlport_req,
  output db_ctrl_pkg::ctrlport_resp_t s_ctrlport_resp,
  // rf switch antenna selects
  output logic [1:0]                  tx_ant_sel,
  output logic [1:0]                  rx_ant_sel
);

  // end of window, widened against wrap
  localparam logic [20:0] END_ADDRESS = {1'b0, BASE_ADDRESS} + {1'b0, SIZE_ADDRESS};

  logic                      in_window;
  logic [19:0]               req_offset;
  logic                      reg_hit;
  logic [31:0]               rd_data;
  logic [31:0]               scratch;
  logic                      resp_ack_q;
  db_ctrl_pkg::ctrl_status_t resp_status_q;
  logic [31:0]               resp_data_q;

  // ------------------------------
  // address decode
  // ------------------------------
  assign in_window = ({1'b0, s_ctrlport_req.addr} >= {1'b0, BASE_ADDRESS}) &&
                     ({1'b0, s_ctrlport_req.addr} < END_ADDRESS);

  assign req_offset = s_ctrlport_req.addr - BASE_ADDRESS;

  // ------------------------------
  // read mux
  // ------------------------------
  // both registers are read/write, so one hit flag covers wr and rd
  always_comb begin
    rd_data = '0;
    reg_hit = 1'b1;
    case (req_offset)
      `SWITCH_CONTROL: begin
        rd_data[`TX_ANT_SEL_MSB:`TX_ANT_SEL_LSB] = tx_ant_sel;
        rd_data[`RX_ANT_SEL_MSB:`RX_ANT_SEL_LSB] = rx_ant_sel;
      end
      `SWITCH_SCRATCH: begin
        // full word
        rd_data = scratch;
      end
      default: begin
        reg_hit = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // control registers
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack_q <= 1'b0;
      tx_ant_sel <= 2'b00;
      rx_ant_sel <= 2'b00;
      scratch    <= '0;
    end else begin
      resp_ack_q <= in_window && (s_ctrlport_req.wr || s_ctrlport_req.rd);
      if (in_window && s_ctrlport_req.wr) begin
        case (req_offset)
          `SWITCH_CONTROL: begin
            tx_ant_sel <= s_ctrlport_req.data[`TX_ANT_SEL_MSB:`TX_ANT_SEL_LSB];
            rx_ant_sel <= s_ctrlport_req.data[`RX_ANT_SEL_MSB:`RX_ANT_SEL_LSB];
          end
          `SWITCH_SCRATCH: begin
            scratch <= s_ctrlport_req.data;
          end
          default: begin
            // holes in the window, nothing stored
          end
        endcase
      end
    end
  end

  // ------------------------------
  // response payload
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    resp_status_q <= reg_hit ? db_ctrl_pkg::ctrl_sts_okay : db_ctrl_pkg::ctrl_sts_cmderr;
    // no read data on writes
    if (s_ctrlport_req.wr) begin
      resp_data_q <= '0;
    end else begin
      resp_data_q <= rd_data;
    end
  end

  assign s_ctrlport_resp = '{ack: resp_ack_q, status: resp_status_q, data: resp_data_q};

endmodule

//--- source/power_regs.sv
`timescale 1ns/1ps

`include "db_ctrl_cfg.svh"

module power_regs #(
  parameter logic [19:0] BASE_ADDRESS = `DB_CTRL_POWER_BASE,
  parameter logic [19:0] SIZE_ADDRESS = `DB_CTRL_POWER_SIZE
) (
  input  logic                        ctrlport_clk,
  input  logic                        ctrlport_rst,
  // ctrlport request and response
  input  db_ctrl_pkg::ctrlport_req_t  s_ctrlport_req,
  output db_ctrl_pkg::ctrlport_resp_t s_ctrlport_resp,
  // supply enables
  output logic                        enable_tx_7v0,
  output logic                        enable_rx_7v0,
  output logic                        enable_3v3,
  // power-good from the 7 V regulators
  input  logic                        p7v_pg_a,
  input  logic                        p7v_pg_b,
  // pll reference clock buffer
  output logic                        pll_ref_clk_enable
);

  // end of window, one bit wider so the sum cannot wrap
  localparam logic [20:0] END_ADDRESS = {1'b0, BASE_ADDRESS} + {1'b0, SIZE_ADDRESS};

  logic                      in_window;
  logic [19:0]               req_offset;
  logic                      wr_hit;
  logic                      rd_hit;
  logic [31:0]               rd_data;
  logic                      resp_ack_q;
  db_ctrl_pkg::ctrl_status_t resp_status_q;
  logic [31:0]               resp_data_q;

  // ------------------------------
  // address decode
  // ------------------------------
  assign in_window = ({1'b0, s_ctrlport_req.addr} >= {1'b0, BASE_ADDRESS}) &&
                     ({1'b0, s_ctrlport_req.addr} < END_ADDRESS);

  // offset inside the window
  // garbage outside, but then nothing answers
  assign req_offset = s_ctrlport_req.addr - BASE_ADDRESS;

  // writable offsets
  // status register is read only, so a write there is a cmderr
  assign wr_hit = (req_offset == `RF_POWER_CONTROL) ||
                  (req_offset == `PRC_CONTROL);

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb begin
    // undefined bits read as zero
    rd_data = '0;
    rd_hit  = 1'b1;
    case (req_offset)
      `RF_POWER_CONTROL: begin
        rd_data[`ENABLE_TX_7V0] = enable_tx_7v0;
        rd_data[`ENABLE_RX_7V0] = enable_rx_7v0;
        rd_data[`ENABLE_3V3]    = enable_3v3;
      end
      `RF_POWER_STATUS: begin
        // live levels, not sampled
        rd_data[`P7V_A_STATUS] = p7v_pg_a;
        rd_data[`P7V_B_STATUS] = p7v_pg_b;
      end
      `PRC_CONTROL: begin
        rd_data[`PLL_REF_CLOCK_ENABLE] = pll_ref_clk_enable;
      end
      default: begin
        // unknown offset, data stays zero
        rd_hit = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // control registers
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack_q         <= 1'b0;
      enable_tx_7v0      <= 1'b0;
      enable_rx_7v0      <= 1'b0;
      enable_3v3         <= 1'b0;
      pll_ref_clk_enable <= 1'b0;
    end else begin
      // any request in our window gets an ack, good or bad
      resp_ack_q <= in_window && (s_ctrlport_req.wr || s_ctrlport_req.rd);
      if (in_window && s_ctrlport_req.wr) begin
        case (req_offset)
          `RF_POWER_CONTROL: begin
            enable_tx_7v0 <= s_ctrlport_req.data[`ENABLE_TX_7V0];
            enable_rx_7v0 <= s_ctrlport_req.data[`ENABLE_RX_7V0];
            enable_3v3    <= s_ctrlport_req.data[`ENABLE_3V3];
          end
          `PRC_CONTROL: begin
            pll_ref_clk_enable <= s_ctrlport_req.data[`PLL_REF_CLOCK_ENABLE];
          end
          default: begin
            // status and holes keep everything as is
          end
        endcase
      end
    end
  end

  // ------------------------------
  // response payload
  // ------------------------------
  // write wins when wr and rd come together
  always_ff @(posedge ctrlport_clk) begin
    if (s_ctrlport_req.wr) begin
      resp_status_q <= wr_hit ? db_ctrl_pkg::ctrl_sts_okay : db_ctrl_pkg::ctrl_sts_cmderr;
      resp_data_q   <= '0;
    end else begin
      resp_status_q <= rd_hit ? db_ctrl_pkg::ctrl_sts_okay : db_ctrl_pkg::ctrl_sts_cmderr;
      // zero already on a miss
      resp_data_q   <= rd_data;
    end
  end

  assign s_ctrlport_resp = '{ack: resp_ack_q, status: resp_status_q, data: resp_data_q};

endmodule

//--- source/db_ctrl_pkg.sv
package db_ctrl_pkg;

  // ------------------------------
  // response status codes
  // ------------------------------
  // only okay and cmderr come out of this design
  typedef enum logic [1:0] {
    ctrl_sts_okay   = 2'd0,
    ctrl_sts_cmderr = 2'd1,
    ctrl_sts_tsferr = 2'd2,
    ctrl_sts_slverr = 2'd3
  } ctrl_status_t;

  // ------------------------------
  // request, 54 bits
  // ------------------------------
  // wr and rd are single cycle pulses
  typedef struct packed {
    logic        wr;
    logic        rd;
    // byte address, 20 bits as on ctrlport
    logic [19:0] addr;
    // write data, ignored on reads
    logic [31:0] data;
  } ctrlport_req_t;

  // ------------------------------
  // response, 35 bits
  // ------------------------------
  // status and data only valid with ack
  typedef struct packed {
    logic         ack;
    ctrl_status_t status;
    // read data, zero on writes and errors
    logic [31:0]  data;
  } ctrlport_resp_t;

endpackage

//--- source/db_ctrl_cfg.svh
`ifndef DB_CTRL_CFG_SVH
`define DB_CTRL_CFG_SVH

// ------------------------------
// address windows
// ------------------------------
// power block, 16 bytes
`define DB_CTRL_POWER_BASE   20'h00000
`define DB_CTRL_POWER_SIZE   20'h00010
// switch block, right after it
`define DB_CTRL_SWITCH_BASE  20'h00010
`define DB_CTRL_SWITCH_SIZE  20'h00010

// ------------------------------
// power block registers
// ------------------------------
`define RF_POWER_CONTROL     20'h0
`define ENABLE_TX_7V0        0
`define ENABLE_RX_7V0        1
`define ENABLE_3V3           2
// read only, power-good levels
`define RF_POWER_STATUS      20'h4
`define P7V_A_STATUS         0
`define P7V_B_STATUS         1
`define PRC_CONTROL          20'h8
`define PLL_REF_CLOCK_ENABLE 0

// ------------------------------
// switch block registers
// ------------------------------
`define SWITCH_CONTROL       20'h0
`define TX_ANT_SEL_MSB       1
`define TX_ANT_SEL_LSB       0
`define RX_ANT_SEL_MSB       5
`define RX_ANT_SEL_LSB       4
`define SWITCH_SCRATCH       20'h4

`endif
